//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
dv/tb_uart.sv

//--- dv/tb_uart.sv
////////////////////
// UART testbench with bus tasks, serial monitor, directed tests and timeout
////////////////////

`timescale 1ns/10ps

module tb_uart;

  import uart_pkg::*;

  localparam int clock_freq_hz  = 10_000_000;
  localparam int baud_rate      = 115_200;
  localparam int div_reset_exp  = clock_freq_hz / (16 * baud_rate) - 1;
  localparam int test_div       = 1;
  localparam int bit_cycles     = 16 * (test_div + 1);
  // Longest frame has two stop bits
  localparam int frame_cycles   = 11 * bit_cycles;
  localparam int num_frames     = 19;
  localparam int timeout_cycles = num_frames * frame_cycles + 3000;
  localparam logic [31:0] lfsr_poly = 32'h8020_0003;

  logic          clock;
  logic          reset;
  uart_bus_req_t bus;
  logic          rxd;
  logic          rxd_drv;
  logic          loopback;
  logic [31:0]   rd_data;
  logic          txd;
  logic          irq;
  logic [31:0]   lfsr;
  int            errors = 0;
  int            checks = 0;
  int            cycles = 0;

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // rxd either follows txd or the serial sender
  assign rxd = loopback ? txd : rxd_drv;

  uart_top #(
    .clock_freq_hz(clock_freq_hz),
    .baud_rate(baud_rate)
  ) i_dut (
    .clock(clock), .reset(reset), .bus(bus), .rxd(rxd),
    .rd_data(rd_data), .txd(txd), .irq(irq)
  );

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ lfsr_poly) : (state >> 1);
  endfunction

  // One LFSR step per bit
  task automatic rand_byte(output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
      value[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic bus_write(input logic [addr_width-1:0] addr, input logic [31:0] data);
    @(negedge clock);
    bus.wr      = 1'b1;
    bus.addr    = addr;
    bus.wr_data = data;
    @(negedge clock);
    bus.wr = 1'b0;
  endtask

  // Read data is registered, valid one cycle after the strobe
  task automatic bus_read(input logic [addr_width-1:0] addr, output logic [31:0] data);
    @(negedge clock);
    bus.rd   = 1'b1;
    bus.addr = addr;
    @(negedge clock);
    bus.rd = 1'b0;
    data   = rd_data;
  endtask

  task automatic read_check(input logic [addr_width-1:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] value;
    bus_read(addr, value);
    check(value, expected, what);
  endtask

  // Serial monitor, samples txd at mid-bit
  task automatic receive_frame(input logic [7:0] expected, input logic two_stop);
    logic [7:0] data;
    @(negedge clock);
    while (txd !== 1'b0) begin
      @(negedge clock);
    end
    repeat (bit_cycles / 2) @(negedge clock);
    check({31'b0, txd}, 32'd0, "txd start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (bit_cycles) @(negedge clock);
      data[i] = txd;
    end
    check({24'b0, data}, {24'b0, expected}, "txd data byte");
    repeat (bit_cycles) @(negedge clock);
    check({31'b0, txd}, 32'd1, "txd stop bit");
    if (two_stop) begin
      repeat (bit_cycles) @(negedge clock);
      check({31'b0, txd}, 32'd1, "txd second stop bit");
    end
  endtask

  task automatic send_frame(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      rxd_drv = frame[i];
      repeat (bit_cycles - 1) @(negedge clock);
    end
  endtask

  task automatic wait_rx_level;
    logic [31:0] value;
    value = '0;
    while (value[rxwm_bit] !== 1'b1) begin
      bus_read(addr_ip, value);
    end
  endtask

  task automatic test_reset;
    logic [31:0] value;
    check({31'b0, txd}, 32'd1, "txd after reset");
    check({31'b0, irq}, 32'd0, "irq after reset");
    read_check(addr_div, 32'(div_reset_exp), "div after reset");
    read_check(addr_txctrl, 32'd0, "txctrl after reset");
    read_check(addr_rxctrl, 32'd0, "rxctrl after reset");
    read_check(addr_ie, 32'd0, "ie after reset");
    read_check(addr_ip, 32'd0, "ip after reset");
    read_check(addr_txdata, 32'd0, "txdata after reset");
    bus_read(addr_rxdata, value);
    check({31'b0, value[31]}, 32'd1, "rxdata empty flag after reset");
    read_check(3'd7, 32'd0, "unused address");
  endtask

  task automatic test_readback;
    // Ones in unused bits must read back as zero
    bus_write(addr_txctrl, 32'hfff2_ffff);
    read_check(addr_txctrl, 32'h0002_0003, "txctrl readback");
    bus_write(addr_rxctrl, 32'hfff5_ffff);
    read_check(addr_rxctrl, 32'h0005_0001, "rxctrl readback");
    bus_write(addr_ie, 32'hffff_fff2);
    read_check(addr_ie, 32'h0000_0002, "ie readback");
    // tx count 0 is below txcnt 2
    read_check(addr_ip, 32'h0000_0001, "ip with txcnt 2");
    bus_write(addr_ie, 32'hffff_fff1);
    read_check(addr_ie, 32'h0000_0001, "ie txwm readback");
    bus_write(addr_div, 32'habcd_0003);
    read_check(addr_div, 32'h0000_0003, "div readback");
    bus_write(addr_txctrl, 32'd0);
    bus_write(addr_rxctrl, 32'd0);
    bus_write(addr_ie, 32'd0);
    bus_write(addr_div, 32'(test_div));
  endtask

  task automatic test_tx_framing;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    rand_byte(b0);
    rand_byte(b1);
    rand_byte(b2);
    bus_write(addr_txdata, {24'b0, b0});
    bus_write(addr_txctrl, 32'h1);
    receive_frame(b0, 1'b0);
    // Queue two frames with two stop bits
    bus_write(addr_txctrl, 32'h2);
    bus_write(addr_txdata, {24'b0, b1});
    bus_write(addr_txdata, {24'b0, b2});
    bus_write(addr_txctrl, 32'h3);
    receive_frame(b1, 1'b1);
    receive_frame(b2, 1'b1);
    bus_write(addr_txctrl, 32'd0);
  endtask

  task automatic test_loopback;
    logic [7:0]  sent [4];
    logic [31:0] value;
    loopback = 1'b1;
    // rxcnt 3 flags four received bytes
    bus_write(addr_rxctrl, 32'h0003_0001);
    for (int i = 0; i < 4; i++) begin
      rand_byte(sent[i]);
      bus_write(addr_txdata, {24'b0, sent[i]});
    end
    bus_write(addr_txctrl, 32'h1);
    for (int i = 0; i < 4; i++) begin
      receive_frame(sent[i], 1'b0);
    end
    wait_rx_level();
    for (int i = 0; i < 4; i++) begin
      bus_read(addr_rxdata, value);
      check(value, {24'b0, sent[i]}, "rxdata loopback byte");
    end
    bus_read(addr_rxdata, value);
    check({31'b0, value[31]}, 32'd1, "rxdata empty after loopback");
    bus_write(addr_txctrl, 32'd0);
    bus_write(addr_rxctrl, 32'd0);
    @(negedge clock);
    loopback = 1'b0;
  endtask

  task automatic test_fifo_full;
    logic [7:0]  data [9];
    logic [31:0] value;
    for (int i = 0; i < 9; i++) begin
      rand_byte(data[i]);
      bus_write(addr_txdata, {24'b0, data[i]});
      bus_read(addr_txdata, value);
      check({31'b0, value[31]}, (i >= 7) ? 32'd1 : 32'd0, "txdata full flag");
    end
    // txcnt 1 makes ip show an empty tx FIFO
    bus_write(addr_txctrl, 32'h0001_0001);
    for (int i = 0; i < 8; i++) begin
      receive_frame(data[i], 1'b0);
    end
    // A ninth frame would start at the end of this stop bit
    repeat (bit_cycles) @(negedge clock);
    check({31'b0, txd}, 32'd1, "txd idle after eight frames");
    read_check(addr_ip, 32'd1, "ip with empty tx FIFO");
    bus_write(addr_txctrl, 32'd0);
  endtask

  task automatic test_watermarks;
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [31:0] value;
    bus_write(addr_rxctrl, 32'h0001_0001);
    bus_write(addr_ie, 32'h2);
    rand_byte(b0);
    rand_byte(b1);
    send_frame(b0);
    check({31'b0, irq}, 32'd0, "irq after one rx byte");
    send_frame(b1);
    check({31'b0, irq}, 32'd1, "irq after two rx bytes");
    bus_read(addr_rxdata, value);
    check(value, {24'b0, b0}, "first rx byte");
    check({31'b0, irq}, 32'd0, "irq after one rx read");
    bus_read(addr_rxdata, value);
    check(value, {24'b0, b1}, "second rx byte");
    bus_write(addr_rxctrl, 32'd0);
    // tx watermark at two bytes
    bus_write(addr_ie, 32'h1);
    bus_write(addr_txctrl, 32'h0002_0000);
    check({31'b0, irq}, 32'd1, "irq with empty tx FIFO");
    rand_byte(b0);
    rand_byte(b1);
    bus_write(addr_txdata, {24'b0, b0});
    check({31'b0, irq}, 32'd1, "irq with one tx byte");
    bus_write(addr_txdata, {24'b0, b1});
    check({31'b0, irq}, 32'd0, "irq with two tx bytes");
    bus_write(addr_txctrl, 32'h0002_0001);
    receive_frame(b0, 1'b0);
    check({31'b0, irq}, 32'd1, "irq after tx FIFO drains");
    receive_frame(b1, 1'b0);
    bus_write(addr_txctrl, 32'd0);
    bus_write(addr_ie, 32'd0);
  endtask

  initial begin
    bus      = '0;
    rxd_drv  = 1'b1;
    loopback = 1'b0;
    reset    = 1'b1;
    lfsr     = 32'hbb61a0cd;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset();
    test_readback();
    test_tx_framing();
    test_loopback();
    test_fifo_full();
    test_watermarks();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/uart_baud_gen.sv
////////////////////
// 16x oversampling tick generator
////////////////////

`timescale 1ns/10ps

module uart_baud_gen (
  input  logic        clock,
  input  logic        reset,
  input  logic [15:0] div,
  output logic        tick
);

  logic [15:0] cnt;
  logic [15:0] prev_div;

  // Down-counter, one tick every div+1 cycles
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cnt      <= '0;
      prev_div <= '0;
      tick     <= 1'b0;
    end else begin
      prev_div <= div;
      tick     <= 1'b0;
      if (div != prev_div) begin
        // New divisor, start a fresh period
        cnt <= div;
      end else if (cnt == 16'd0) begin
        cnt  <= div;
        tick <= 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

//--- rtl/uart_fifo.sv
////////////////////
// Byte FIFO with count, full and empty
////////////////////

`timescale 1ns/10ps

module uart_fifo #(
  parameter int depth = 8
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       pop,
  output logic [7:0] pop_data,
  output logic [3:0] count,
  output logic       full,
  output logic       empty
);

  localparam int ptr_width = $clog2(depth);

  logic [7:0]           mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  // Ignore push when full and pop when empty
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign full     = (count == 4'(depth));
  assign empty    = (count == 4'd0);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- rtl/uart_pkg.sv
////////////////////
// UART register map, bus and control structs, field positions and widths
////////////////////

package uart_pkg;

  // FIFO and address geometry
  localparam int fifo_depth = 8;
  localparam int addr_width = 3;
  localparam int cnt_width  = 3;
  localparam int div_width  = 16;

  // Word addresses of the registers, address 7 reads zero
  localparam logic [addr_width-1:0] addr_txdata = 3'd0;
  localparam logic [addr_width-1:0] addr_rxdata = 3'd1;
  localparam logic [addr_width-1:0] addr_txctrl = 3'd2;
  localparam logic [addr_width-1:0] addr_rxctrl = 3'd3;
  localparam logic [addr_width-1:0] addr_ie     = 3'd4;
  localparam logic [addr_width-1:0] addr_ip     = 3'd5;
  localparam logic [addr_width-1:0] addr_div    = 3'd6;

  // Register field bit positions
  localparam int flag_bit  = 31;
  localparam int en_bit    = 0;
  localparam int nstop_bit = 1;
  localparam int cnt_lsb   = 16;
  localparam int cnt_msb   = 18;
  localparam int txwm_bit  = 0;
  localparam int rxwm_bit  = 1;

  // Single-cycle bus request
  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic [addr_width-1:0] addr;
    logic [31:0]           wr_data;
  } uart_bus_req_t;

  // Programmed control fields
  typedef struct packed {
    logic                 txen;
    logic                 nstop;
    logic                 rxen;
    logic [cnt_width-1:0] txcnt;
    logic [cnt_width-1:0] rxcnt;
    logic [div_width-1:0] div;
  } uart_ctrl_t;

endpackage

//--- rtl/uart_regs.sv
////////////////////
// Register file, read mux, FIFO strobes and interrupt
////////////////////

`timescale 1ns/10ps

module uart_regs #(
  parameter logic [15:0] div_reset = 16'd26
) (
  input  logic                   clock,
  input  logic                   reset,
  input  uart_pkg::uart_bus_req_t bus,
  input  logic [3:0]             tx_count,
  input  logic                   tx_full,
  input  logic [7:0]             rx_data,
  input  logic [3:0]             rx_count,
  input  logic                   rx_empty,
  output logic [31:0]            rd_data,
  output uart_pkg::uart_ctrl_t   ctrl,
  output logic                   tx_push,
  output logic [7:0]             tx_push_data,
  output logic                   rx_pop,
  output logic                   irq
);

  import uart_pkg::*;

  logic [1:0]  ie;
  logic [1:0]  ip;
  logic [31:0] rd_mux;

  // FIFO strobes straight from the bus
  assign tx_push      = bus.wr && (bus.addr == addr_txdata) && !tx_full;
  assign tx_push_data = bus.wr_data[7:0];
  assign rx_pop       = bus.rd && (bus.addr == addr_rxdata) && !rx_empty;

  // Watermark pending bits
  assign ip[txwm_bit] = tx_count < {1'b0, ctrl.txcnt};
  assign ip[rxwm_bit] = rx_count > {1'b0, ctrl.rxcnt};
  assign irq          = |(ip & ie);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ctrl <= '{txen: 1'b0, nstop: 1'b0, rxen: 1'b0, txcnt: '0, rxcnt: '0, div: div_reset};
      ie   <= '0;
    end else if (bus.wr) begin
      case (bus.addr)
        addr_txctrl: begin
          ctrl.txen  <= bus.wr_data[en_bit];
          ctrl.nstop <= bus.wr_data[nstop_bit];
          ctrl.txcnt <= bus.wr_data[cnt_msb:cnt_lsb];
        end
        addr_rxctrl: begin
          ctrl.rxen  <= bus.wr_data[en_bit];
          ctrl.rxcnt <= bus.wr_data[cnt_msb:cnt_lsb];
        end
        addr_ie: begin
          ie <= bus.wr_data[1:0];
        end
        addr_div: begin
          ctrl.div <= bus.wr_data[div_width-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Read mux, unused bits read zero
  always_comb begin
    rd_mux = '0;
    case (bus.addr)
      addr_txdata: begin
        rd_mux[flag_bit] = tx_full;
      end
      addr_rxdata: begin
        rd_mux[flag_bit] = rx_empty;
        rd_mux[7:0]      = rx_data;
      end
      addr_txctrl: begin
        rd_mux[en_bit]          = ctrl.txen;
        rd_mux[nstop_bit]       = ctrl.nstop;
        rd_mux[cnt_msb:cnt_lsb] = ctrl.txcnt;
      end
      addr_rxctrl: begin
        rd_mux[en_bit]          = ctrl.rxen;
        rd_mux[cnt_msb:cnt_lsb] = ctrl.rxcnt;
      end
      addr_ie: rd_mux[1:0] = ie;
      addr_ip: rd_mux[1:0] = ip;
      addr_div: rd_mux[div_width-1:0] = ctrl.div;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
    end else if (bus.rd) begin
      rd_data <= rd_mux;
    end
  end

endmodule

//--- rtl/uart_rx.sv
////////////////////
// UART receiver with synchronizer and mid-bit sampling
////////////////////

`timescale 1ns/10ps

module uart_rx (
  input  logic               clock,
  input  logic               reset,
  input  logic               tick,
  input  uart_pkg::uart_ctrl_t ctrl,
  input  logic               rxd,
  output logic               push,
  output logic [7:0]         push_data
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t     state;
  logic [1:0] sync;
  logic       rx_s;
  logic [3:0] tick_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic       sample;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  assign rx_s   = sync[1];
  assign sample = tick && (tick_cnt == 4'd15);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      if (state != st_idle && tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          if (ctrl.rxen && !rx_s) begin
            state    <= st_start;
            tick_cnt <= '0;
          end
        end
        st_start: begin
          // Recheck at mid start bit, a short pulse is a glitch
          if (tick && tick_cnt == 4'd7) begin
            if (!rx_s) begin
              state    <= st_data;
              tick_cnt <= '0;
              bit_cnt  <= '0;
            end else begin
              state <= st_idle;
            end
          end
        end
        st_data: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          // Mid stop bit, hand the byte over
          if (sample) begin
            push  <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_data && sample) begin
      shift <= {rx_s, shift[7:1]};
    end
  end

  assign push_data = shift;

endmodule

//--- rtl/uart_top.sv
////////////////////
// UART peripheral top level
////////////////////

`timescale 1ns/10ps

module uart_top #(
  parameter int clock_freq_hz = 10_000_000,
  parameter int baud_rate     = 115_200
) (
  input  logic                   clock,
  input  logic                   reset,
  input  uart_pkg::uart_bus_req_t bus,
  input  logic                   rxd,
  output logic [31:0]            rd_data,
  output logic                   txd,
  output logic                   irq
);

  import uart_pkg::*;

  localparam int div_calc = clock_freq_hz / (16 * baud_rate) - 1;

  uart_ctrl_t ctrl;
  logic       tick;
  logic       tx_push;
  logic [7:0] tx_push_data;
  logic       tx_pop;
  logic [7:0] tx_head;
  logic [3:0] tx_count;
  logic       tx_full;
  logic       tx_empty;
  logic       rx_push;
  logic [7:0] rx_push_data;
  logic       rx_pop;
  logic [7:0] rx_head;
  logic [3:0] rx_count;
  logic       rx_empty;

  uart_regs #(
    .div_reset(16'(div_calc))
  ) u_regs (
    .clock(clock), .reset(reset), .bus(bus),
    .tx_count(tx_count), .tx_full(tx_full),
    .rx_data(rx_head), .rx_count(rx_count), .rx_empty(rx_empty),
    .rd_data(rd_data), .ctrl(ctrl),
    .tx_push(tx_push), .tx_push_data(tx_push_data),
    .rx_pop(rx_pop), .irq(irq)
  );

  uart_fifo #(.depth(fifo_depth)) u_tx_fifo (
    .clock(clock), .reset(reset),
    .push(tx_push), .push_data(tx_push_data), .pop(tx_pop),
    .pop_data(tx_head), .count(tx_count), .full(tx_full), .empty(tx_empty)
  );

  // A full rx FIFO drops the incoming byte
  uart_fifo #(.depth(fifo_depth)) u_rx_fifo (
    .clock(clock), .reset(reset),
    .push(rx_push), .push_data(rx_push_data), .pop(rx_pop),
    .pop_data(rx_head), .count(rx_count), .full(), .empty(rx_empty)
  );

  uart_baud_gen u_baud (
    .clock(clock), .reset(reset), .div(ctrl.div), .tick(tick)
  );

  uart_tx u_tx (
    .clock(clock), .reset(reset), .tick(tick), .ctrl(ctrl),
    .fifo_data(tx_head), .fifo_empty(tx_empty),
    .fifo_pop(tx_pop), .txd(txd)
  );

  uart_rx u_rx (
    .clock(clock), .reset(reset), .tick(tick), .ctrl(ctrl),
    .rxd(rxd), .push(rx_push), .push_data(rx_push_data)
  );

endmodule

//--- rtl/uart_tx.sv
////////////////////
// UART transmitter FSM and shifter
////////////////////

`timescale 1ns/10ps

module uart_tx (
  input  logic               clock,
  input  logic               reset,
  input  logic               tick,
  input  uart_pkg::uart_ctrl_t ctrl,
  input  logic [7:0]         fifo_data,
  input  logic               fifo_empty,
  output logic               fifo_pop,
  output logic               txd
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t     state;
  logic [3:0] tick_cnt;
  logic [2:0] bit_cnt;
  logic       second_stop;
  logic [7:0] shift;
  logic       bit_end;
  logic       frame_done;
  logic       load;

  assign bit_end    = tick && (tick_cnt == 4'd15);
  assign frame_done = (state == st_stop) && bit_end && (second_stop || !ctrl.nstop);
  // Start on a tick so the start bit is a full 16 ticks long
  assign load       = tick && ctrl.txen && !fifo_empty && (state == st_idle || frame_done);
  assign fifo_pop   = load;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= st_idle;
      tick_cnt    <= '0;
      bit_cnt     <= '0;
      second_stop <= 1'b0;
    end else if (load) begin
      state    <= st_start;
      tick_cnt <= '0;
    end else begin
      if (state != st_idle && tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      if (bit_end) begin
        case (state)
          st_start: begin
            state   <= st_data;
            bit_cnt <= '0;
          end
          st_data: begin
            if (bit_cnt == 3'd7) begin
              state       <= st_stop;
              second_stop <= 1'b0;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          st_stop: begin
            if (second_stop || !ctrl.nstop) begin
              state <= st_idle;
            end else begin
              second_stop <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // LSB first
  always_ff @(posedge clock) begin
    if (load) begin
      shift <= fifo_data;
    end else if (state == st_data && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  assign txd = (state == st_start) ? 1'b0 :
               (state == st_data)  ? shift[0] : 1'b1;

endmodule
